/* include/cart_defs.svh */
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

////////////////////////////////////////////////////////////
// sd control window, memory mapped in the primary slot
////////////////////////////////////////////////////////////

`define SDC_ENABLE      16'h7E00    // bit 0 enables the window
`define SDC_CMD         16'h7E01    // command byte, sticky bits
`define SDC_STATUS      16'h7E02
`define SDC_SADDR       16'h7E03    // four sector bytes, lsb first
`define SDC_END         16'h7EFF

// mapper type select, i/o space
`define MAPPER_PORT     8'h8F

// command byte layout
`define CMD_RSTART_BIT  0
`define CMD_WSTART_BIT  1
`define CMD_INIT_BIT    7

// flops per pin before capture
`define SYNC_STAGES     2

// bus widths
`define ADDR_W          16
`define DATA_W          8
`define SECTOR_W        32
`define MAPPER_W        2

`endif

/* hdl/cart_pkg.sv */
`include "cart_defs.svh"

package cart_pkg;

    typedef logic [`ADDR_W-1:0]   addr_t;     // z80 address
    typedef logic [`DATA_W-1:0]   data_t;
    typedef logic [`SECTOR_W-1:0] sector_t;   // sd block number

    // 0 konami, 1 konami scc+, 2 ascii16, 3 ascii8
    typedef logic [`MAPPER_W-1:0] mapper_t;

    ////////////////////////////////////////////////////////////
    // dot sequencer, one full round is eight clk108 cycles
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        LO_SEL,     // point mux at a0-a7
        LO_CAP,
        HI_SEL,     // a8-a15
        HI_CAP,
        CTL_SEL,    // merq, iorq, m1
        CTL_CAP,
        IDLE_SEL,   // mux off
        IDLE_WAIT
    } dot_phase_e;

endpackage

/* hdl/bus_decode.sv */
`include "cart_defs.svh"

module bus_decode (
    input  logic             clk108_w,
    input  logic             ram_enabled_w,
    input  cart_pkg::data_t  mp,
    input  cart_pkg::data_t  cd_in,
    input  logic             rd_n,
    input  logic             wr_n,
    input  logic             sltsl_n,
    output logic [2:0]       msel_n,
    output cart_pkg::addr_t  addr,
    output cart_pkg::data_t  wdata,
    output logic             mem_wr,
    output logic             mem_rd,
    output logic             io_wr,
    output logic             slot_rd
);
    import cart_pkg::*;

    dot_phase_e phase;
    logic       dot_ena;
    logic [3:0] strb_pipe [`SYNC_STAGES];   // {dot_ena, msel_n} aligned with synced pins
    data_t      mp_sync [`SYNC_STAGES];
    data_t      cd_sync [`SYNC_STAGES];
    logic [2:0] pin_sync [`SYNC_STAGES];    // {rd_n, wr_n, sltsl_n}
    logic       cap_ena;
    logic [2:0] cap_sel;
    data_t      addr_lo;
    data_t      addr_hi;
    logic       merq_q, iorq_q, m1_q;
    logic       rd_q, wr_q, slt_q;

    ////////////////////////////////////////////////////////////
    // sequencer and mux select
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            phase   <= LO_SEL;
            msel_n  <= 3'b111;
            dot_ena <= 1'b0;
        end else begin
            phase   <= phase.next();    // wraps after IDLE_WAIT
            dot_ena <= (phase == LO_CAP) || (phase == HI_CAP) || (phase == CTL_CAP);
            case (phase)
                LO_SEL:   msel_n <= 3'b110;
                HI_SEL:   msel_n <= 3'b101;
                CTL_SEL:  msel_n <= 3'b011;
                IDLE_SEL: msel_n <= 3'b111;
                default:  msel_n <= msel_n;
            endcase
        end
    end

    // strobe rides along with the synchroniser delay
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            for (int i = 0; i < `SYNC_STAGES; i++) begin
                strb_pipe[i] <= 4'b0111;
                pin_sync[i]  <= 3'b111;
            end
        end else begin
            strb_pipe[0] <= {dot_ena, msel_n};
            pin_sync[0]  <= {rd_n, wr_n, sltsl_n};
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                strb_pipe[i] <= strb_pipe[i-1];
                pin_sync[i]  <= pin_sync[i-1];
            end
        end
    end

    always_ff @(posedge clk108_w) begin
        mp_sync[0] <= mp;
        cd_sync[0] <= cd_in;
        for (int i = 1; i < `SYNC_STAGES; i++) begin
            mp_sync[i] <= mp_sync[i-1];
            cd_sync[i] <= cd_sync[i-1];
        end
    end

    assign cap_ena = strb_pipe[`SYNC_STAGES-1][3];
    assign cap_sel = strb_pipe[`SYNC_STAGES-1][2:0];

    ////////////////////////////////////////////////////////////
    // snapshot capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk108_w) begin
        if (cap_ena) begin
            wdata <= cd_sync[`SYNC_STAGES-1];
            if (cap_sel == 3'b110) addr_lo <= mp_sync[`SYNC_STAGES-1];
            if (cap_sel == 3'b101) addr_hi <= mp_sync[`SYNC_STAGES-1];
            if (cap_sel == 3'b011) addr <= {addr_hi, addr_lo};   // whole address per round
        end
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            {merq_q, iorq_q, m1_q} <= 3'b111;
            {rd_q, wr_q, slt_q}    <= 3'b111;
        end else if (cap_ena) begin
            {rd_q, wr_q, slt_q} <= pin_sync[`SYNC_STAGES-1];
            if (cap_sel == 3'b011) begin
                merq_q <= mp_sync[`SYNC_STAGES-1][0];
                iorq_q <= mp_sync[`SYNC_STAGES-1][1];
                m1_q   <= mp_sync[`SYNC_STAGES-1][7];
            end
        end
    end

    // access levels, m1 high keeps interrupt ack cycles out
    assign mem_wr  = !slt_q && !merq_q && iorq_q && m1_q && !wr_q;
    assign mem_rd  = !slt_q && !merq_q && iorq_q && m1_q && !rd_q;
    assign io_wr   = !iorq_q && m1_q && !wr_q;
    assign slot_rd = !slt_q && !rd_q;

    a_msel_onehot: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        $countones(~msel_n) <= 1);

endmodule

/* hdl/sd_ctrl_regs.sv */
`include "cart_defs.svh"

module sd_ctrl_regs (
    input  logic              clk108_w,
    input  logic              ram_enabled_w,
    input  cart_pkg::addr_t   addr,
    input  cart_pkg::data_t   wdata,
    input  logic              mem_wr,
    input  logic              mem_rd,
    input  logic              sd_done,
    input  logic              sd_busy,
    input  logic              sd_crc_error,
    input  logic              sd_timeout_error,
    output logic              sd_rstart,
    output logic              sd_wstart,
    output logic              sd_init,
    output cart_pkg::sector_t sd_sector,
    output logic              rd_hit,
    output cart_pkg::data_t   rd_data
);
    logic sd_en;
    logic in_win;
    logic wr_ok;
    logic cmd_wr;

    assign in_win = (addr >= `SDC_ENABLE) && (addr <= `SDC_END);
    assign wr_ok  = mem_wr && sd_en && in_win;
    assign cmd_wr = wr_ok && (addr == `SDC_CMD);

    // enable is reachable even with the window closed
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_en <= 1'b0;
        end else if (mem_wr && addr == `SDC_ENABLE) begin
            sd_en <= wdata[0];
        end
    end

    ////////////////////////////////////////////////////////////
    // command strobes and sector number
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_rstart <= 1'b0;
            sd_wstart <= 1'b0;
            sd_init   <= 1'b0;
            sd_sector <= '0;
        end else begin
            if (sd_done) begin
                sd_rstart <= 1'b0;
                sd_wstart <= 1'b0;
            end
            if (cmd_wr) begin   // newly set bits beat the done clear
                sd_rstart <= (sd_rstart && !sd_done) || wdata[`CMD_RSTART_BIT];
                sd_wstart <= (sd_wstart && !sd_done) || wdata[`CMD_WSTART_BIT];
                sd_init   <= sd_init   | wdata[`CMD_INIT_BIT];
            end
            if (wr_ok) begin
                case (addr)
                    `SDC_SADDR:         sd_sector[7:0]   <= wdata;
                    `SDC_SADDR + 16'd1: sd_sector[15:8]  <= wdata;
                    `SDC_SADDR + 16'd2: sd_sector[23:16] <= wdata;
                    `SDC_SADDR + 16'd3: sd_sector[31:24] <= wdata;
                    default:            sd_sector        <= sd_sector;
                endcase
            end
        end
    end

    // read back, sector bytes and card id fall to ffh
    always_comb begin
        case (addr)
            `SDC_ENABLE: rd_data = {7'b0, sd_en};
            `SDC_STATUS: rd_data = {sd_busy, 5'b0, sd_timeout_error, sd_crc_error};
            default:     rd_data = 8'hFF;
        endcase
    end

    assign rd_hit = mem_rd && sd_en && in_win;

    // a done pulse always wins unless the host rearms the read in the same cycle
    a_rstart_done: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        (sd_done && !(cmd_wr && wdata[`CMD_RSTART_BIT])) |=> !sd_rstart);

endmodule

/* hdl/mapper_config.sv */
`include "cart_defs.svh"

module mapper_config (
    input  logic              clk108_w,
    input  logic              ram_enabled_w,
    input  cart_pkg::addr_t   addr,
    input  cart_pkg::data_t   wdata,
    input  logic              io_wr,
    output cart_pkg::mapper_t mapper_type,
    output logic              scc_enable
);
    logic port_hit;

    assign port_hit = io_wr && (addr[7:0] == `MAPPER_PORT);   // only a0-a7 decode on i/o

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            mapper_type <= 2'd0;    // konami, no scc
            scc_enable  <= 1'b0;
        end else if (port_hit) begin
            scc_enable <= 1'b0;
            case (wdata)
                8'h05: begin
                    mapper_type <= 2'd1;    // konami scc+
                    scc_enable  <= 1'b1;
                end
                8'h16:   mapper_type <= 2'd2;   // ascii16
                8'h08:   mapper_type <= 2'd3;   // ascii8
                default: mapper_type <= 2'd0;
            endcase
        end
    end

endmodule

/* hdl/bus_response.sv */
module bus_response (
    input  logic            clk108_w,
    input  logic            ram_enabled_w,
    input  logic            slot_rd,
    input  logic            rd_hit,
    input  cart_pkg::data_t rd_data,
    output cart_pkg::data_t cd_out,
    output logic            datadir
);

    ////////////////////////////////////////////////////////////
    // data toward the host
    ////////////////////////////////////////////////////////////

    // last byte read stays on the pins
    always_ff @(posedge clk108_w) begin
        if (rd_hit) begin
            cd_out <= rd_data;
        end
    end

    // low drives cd toward the z80
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            datadir <= 1'b1;
        end else begin
            datadir <= !slot_rd;
        end
    end

    // the board only turns the buffer around for a slot read
    a_dir_slot: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        !datadir |-> $past(slot_rd));

endmodule

/* hdl/cart_bus_top.sv */
module cart_bus_top (
    input  logic              clk108_w,
    input  logic              ram_enabled_w,
    input  cart_pkg::data_t   mp,
    input  cart_pkg::data_t   cd_in,
    input  logic              rd_n,
    input  logic              wr_n,
    input  logic              sltsl_n,
    output logic [2:0]        msel_n,
    input  logic              sd_done,
    input  logic              sd_busy,
    input  logic              sd_crc_error,
    input  logic              sd_timeout_error,
    output logic              sd_rstart,
    output logic              sd_wstart,
    output logic              sd_init,
    output cart_pkg::sector_t sd_sector,
    output cart_pkg::mapper_t mapper_type,
    output logic              scc_enable,
    output cart_pkg::data_t   cd_out,
    output logic              datadir
);
    import cart_pkg::*;

    addr_t addr;
    data_t wdata;
    data_t rd_data;
    logic  mem_wr, mem_rd, io_wr, slot_rd;
    logic  rd_hit;

    bus_decode u_decode (
        .clk108_w, .ram_enabled_w, .mp, .cd_in, .rd_n, .wr_n, .sltsl_n,
        .msel_n, .addr, .wdata, .mem_wr, .mem_rd, .io_wr, .slot_rd
    );

    sd_ctrl_regs u_sd_regs (
        .clk108_w, .ram_enabled_w, .addr, .wdata, .mem_wr, .mem_rd,
        .sd_done, .sd_busy, .sd_crc_error, .sd_timeout_error,
        .sd_rstart, .sd_wstart, .sd_init, .sd_sector, .rd_hit, .rd_data
    );

    mapper_config u_mapper (
        .clk108_w, .ram_enabled_w, .addr, .wdata, .io_wr, .mapper_type, .scc_enable
    );

    bus_response u_resp (
        .clk108_w, .ram_enabled_w, .slot_rd, .rd_hit, .rd_data, .cd_out, .datadir
    );

endmodule

/* bench/msx_host_model.sv */
module msx_host_model (
    input  logic        clk108_w,
    input  logic [2:0]  msel_n,
    input  logic        start,
    input  logic [2:0]  kind,       // 1 mem wr, 2 mem rd, 3 io wr, 6 mem rd with slot off
    input  logic [15:0] req_addr,
    input  logic [7:0]  req_data,
    output logic [7:0]  mp,
    output logic [7:0]  cd_in,
    output logic        rd_n,
    output logic        wr_n,
    output logic        sltsl_n,
    output logic        busy,
    output logic        hold_end
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] a_bus;
    logic        merq_n;
    logic        iorq_n;
    logic        m1_n;

    // board mux, follows msel_n with no delay
    always_comb begin
        case (msel_n)
            3'b110:  mp = a_bus[7:0];
            3'b101:  mp = a_bus[15:8];
            3'b011:  mp = {m1_n, 5'b11111, iorq_n, merq_n};
            default: mp = 8'hFF;                    // nothing selected
        endcase
    end

    initial begin
        a_bus    = '0;
        cd_in    = '0;
        merq_n   = 1'b1;
        iorq_n   = 1'b1;
        m1_n     = 1'b1;    // never an opcode fetch
        rd_n     = 1'b1;
        wr_n     = 1'b1;
        sltsl_n  = 1'b1;
        busy     = 1'b0;
        hold_end = 1'b0;
        forever begin
            @(posedge clk108_w);
            if (start) begin
                busy   <= 1'b1;
                a_bus  <= req_addr;
                cd_in  <= req_data;
                merq_n <= (kind == 3'd3);
                iorq_n <= (kind != 3'd3);
                repeat (16) @(posedge clk108_w);    // address and controls settle first
                wr_n    <= !(kind == 3'd1 || kind == 3'd3);
                rd_n    <= !(kind == 3'd2 || kind == 3'd6);
                sltsl_n <= !(kind == 3'd1 || kind == 3'd2);
                repeat (63) @(posedge clk108_w);
                hold_end <= 1'b1;                   // last cycle of the hold
                @(posedge clk108_w);
                hold_end <= 1'b0;
                rd_n     <= 1'b1;
                wr_n     <= 1'b1;
                sltsl_n  <= 1'b1;
                repeat (16) @(posedge clk108_w);
                merq_n <= 1'b1;
                iorq_n <= 1'b1;
                busy   <= 1'b0;
            end
        end
    end

endmodule

/* bench/tb_cart_bus.sv */
module tb_cart_bus;
    timeunit 1ns;
    timeprecision 1ps;

    localparam string DATA_FILE = "bench/cart_bus_testdata.txt";
    localparam int    MAX_LINES = 64;

    logic        clk108_w = 1'b0;
    logic        ram_enabled_w;
    logic [7:0]  mp, cd_in, cd_out;
    logic        rd_n, wr_n, sltsl_n;
    logic [2:0]  msel_n;
    logic        sd_done, sd_busy, sd_crc_error, sd_timeout_error;
    logic        sd_rstart, sd_wstart, sd_init;
    logic [31:0] sd_sector;
    logic [1:0]  mapper_type;
    logic        scc_enable, datadir;
    logic        start, busy, hold_end;
    logic [2:0]  kind;
    logic [15:0] req_addr;
    logic [7:0]  req_data;

    logic [31:0] td [MAX_LINES*6];  // six words per access line
    int          n_lines = 0;
    int          wd_limit = 0;
    int          errors = 0;
    int          checks = 0;

    always #5 clk108_w = ~clk108_w;

    cart_bus_top i_dut (.*);

    msx_host_model u_host (
        .clk108_w, .msel_n, .start, .kind, .req_addr, .req_data,
        .mp, .cd_in, .rd_n, .wr_n, .sltsl_n, .busy, .hold_end
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // two clocks per group: lo, hi, ctl, idle
    function automatic logic [2:0] mux_select(int step);
        case ((step / 2) % 4)
            0:       return 3'b110;
            1:       return 3'b101;
            2:       return 3'b011;
            default: return 3'b111;
        endcase
    endfunction

    task automatic check_mux_round();
        checks++;
        if (datadir !== 1'b1 || {sd_rstart, sd_wstart, sd_init} !== 3'b000) begin
            errors++;
            $display("Error @%0t: datadir %b strobes %b%b%b after reset", $time,
                     datadir, sd_rstart, sd_wstart, sd_init);
        end
        while (msel_n !== 3'b111) @(negedge clk108_w);
        while (msel_n !== 3'b110) @(negedge clk108_w);  // start of a round
        for (int k = 0; k < 16; k++) begin
            checks++;
            if (msel_n !== mux_select(k)) begin
                errors++;
                $display("Error @%0t: msel_n %b on step %0d, expected %b", $time,
                         msel_n, k, mux_select(k));
            end
            @(negedge clk108_w);
        end
    endtask

    task automatic run_access(input logic [2:0] op, input logic [15:0] a, input logic [7:0] d);
        @(posedge clk108_w);
        kind     <= op;
        req_addr <= a;
        req_data <= d;
        start    <= 1'b1;
        @(posedge clk108_w);
        start <= 1'b0;
        do @(negedge clk108_w); while (!hold_end);
    endtask

    task automatic pulse_done();
        @(posedge clk108_w);
        sd_done <= 1'b1;
        @(posedge clk108_w);
        sd_done <= 1'b0;
        @(negedge clk108_w);
    endtask

    task automatic set_status(input logic [7:0] s);
        @(posedge clk108_w);
        sd_busy          <= s[7];
        sd_timeout_error <= s[1];
        sd_crc_error     <= s[0];
        @(negedge clk108_w);
    endtask

    task automatic check_outputs(input int line, input logic [31:0] exp_sector,
                                 input logic [7:0] exp_flags, input logic [8:0] exp_cd);
        logic [7:0] flags;
        flags = {1'b0, datadir, mapper_type, scc_enable, sd_init, sd_wstart, sd_rstart};
        checks++;
        if (sd_sector !== exp_sector) begin
            errors++;
            $display("Error @%0t: line %0d sd_sector %h, expected %h", $time, line,
                     sd_sector, exp_sector);
        end
        if (flags !== exp_flags) begin
            errors++;
            $display("Error @%0t: line %0d flags %h, expected %h", $time, line,
                     flags, exp_flags);
        end
        if (!exp_cd[8] && cd_out !== exp_cd[7:0]) begin    // bit 8 masks the byte
            errors++;
            $display("Error @%0t: line %0d cd_out %h, expected %h", $time, line,
                     cd_out, exp_cd[7:0]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////
    initial begin : main_seq
        int fd;
        int base;
        int gap;
        ram_enabled_w    = 1'b0;
        sd_done          = 1'b0;
        sd_busy          = 1'b0;
        sd_crc_error     = 1'b0;
        sd_timeout_error = 1'b0;
        start            = 1'b0;
        kind             = '0;
        req_addr         = '0;
        req_data         = '0;
        void'($urandom(32'h9e39));
        for (int i = 0; i < MAX_LINES * 6; i++) begin
            td[i] = 32'hFFFF_FFFF;  // end marker
        end
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("test data file %s could not be opened", DATA_FILE);
        end else begin
            $fclose(fd);
            $readmemh(DATA_FILE, td);
            while (n_lines < MAX_LINES && td[n_lines * 6] != 32'hFFFF_FFFF)
                n_lines++;
            if (n_lines == 0) begin
                errors++;
                $display("test data file %s holds no access lines", DATA_FILE);
            end
            wd_limit = n_lines * 100 + 1000;
            repeat (10) @(posedge clk108_w);
            ram_enabled_w <= 1'b1;
            check_mux_round();
            for (int i = 0; i < n_lines; i++) begin
                base = i * 6;
                case (td[base][2:0])
                    3'd4:    pulse_done();
                    3'd5:    set_status(td[base + 2][7:0]);
                    default: run_access(td[base][2:0], td[base + 1][15:0], td[base + 2][7:0]);
                endcase
                check_outputs(i + 1, td[base + 3], td[base + 4][7:0], td[base + 5][8:0]);
                while (busy) @(negedge clk108_w);
                gap = 8 + int'($urandom % 32'd24);
                repeat (gap) @(posedge clk108_w);
            end
        end
        $display("summary: %0d lines, %0d checks, %0d errors", n_lines, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        wait (wd_limit != 0);
        repeat (wd_limit) @(posedge clk108_w);
        $display("timeout: test sequence still running after %0d cycles", wd_limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* bench/cart_bus_testdata.txt */
// op addr data sector flags cd  (op 1 mem wr, 2 mem rd, 3 io wr, 4 sd_done, 5 status, 6 rd slot off)
// flags 6 datadir, 5:4 mapper_type, 3 scc_enable, 2 init, 1 wstart, 0 rstart; cd 100 = unchecked
1 7E03 55 00000000 40 100
1 7E01 83 00000000 40 100
1 7E00 01 00000000 40 100
1 7E03 78 00000078 40 100
1 7E04 56 00005678 40 100
1 7E05 34 00345678 40 100
1 7E06 12 12345678 40 100
1 7E01 83 12345678 47 100
4 0000 00 12345678 44 100
5 0000 83 12345678 44 100
2 7E02 00 12345678 04 83
5 0000 01 12345678 44 83
2 7E02 00 12345678 04 01
2 7E10 00 12345678 04 FF
2 7E00 00 12345678 04 01
6 7E02 00 12345678 44 01
3 008F 05 12345678 5C 01
3 0090 16 12345678 5C 01
3 008F 16 12345678 64 01
3 008F 08 12345678 74 01
3 008F 33 12345678 44 01
1 7E01 01 12345678 45 01
4 0000 00 12345678 44 01

/* cart_bus.f */
+incdir+include
hdl/cart_pkg.sv
hdl/bus_decode.sv
hdl/sd_ctrl_regs.sv
hdl/mapper_config.sv
hdl/bus_response.sv
hdl/cart_bus_top.sv
bench/msx_host_model.sv
bench/tb_cart_bus.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cart bus testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f cart_bus.f --top-module tb_cart_bus -o sim_cart_bus

./obj_dir/sim_cart_bus > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
